// ==== axis_out_pkg.sv ====
`default_nettype none

package axis_out_pkg;

   localparam int DATA_W      = 32;
   localparam int FIFO_ADDR_W = 4;
   localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;
   localparam int LEVEL_W     = FIFO_ADDR_W + 1;

   // cpu register map
   typedef enum logic [2:0] {
      REG_ENABLE     = 3'd0,
      REG_SOFT_RESET = 3'd1,
      REG_DATA       = 3'd2,
      REG_NWORDS     = 3'd3,
      REG_THRESHOLD  = 3'd4,
      REG_STATUS     = 3'd5
   } reg_addr_e;

   // IDLE holds no word, STREAM presents one
   typedef enum logic {
      IDLE   = 1'b0,
      STREAM = 1'b1
   } ctrl_state_e;

   typedef struct packed {
      logic               enable;
      logic               soft_rst;
      logic [DATA_W-1:0]  nwords;
      logic [LEVEL_W-1:0] threshold;
   } cfg_t;

   // packed low in the status register
   typedef struct packed {
      logic               empty;
      logic               full;
      logic [LEVEL_W-1:0] level;
   } fifo_stat_t;

endpackage

`default_nettype wire

// ==== axis_out_regs.sv ====
`default_nettype none

module axis_out_regs (
   input  wire                               clk_i,
   input  wire                               arst_n_i,
   input  wire                               reg_we_i,
   input  axis_out_pkg::reg_addr_e           reg_addr_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   reg_wdata_i,
   output logic [axis_out_pkg::DATA_W-1:0]   reg_rdata_o,
   input  axis_out_pkg::fifo_stat_t          fifo_stat_i,
   output axis_out_pkg::cfg_t                cfg_o,
   output logic                              cpu_push_o,
   output logic [axis_out_pkg::DATA_W-1:0]   cpu_data_o,
   output logic                              data_wready_o,
   output logic                              interrupt_o
);

   axis_out_pkg::cfg_t cfg_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_q <= '0;
      end else if (reg_we_i) begin
         case (reg_addr_i)
            axis_out_pkg::REG_ENABLE:     cfg_q.enable    <= reg_wdata_i[0];
            axis_out_pkg::REG_SOFT_RESET: cfg_q.soft_rst  <= reg_wdata_i[0];
            axis_out_pkg::REG_NWORDS:     cfg_q.nwords    <= reg_wdata_i;
            axis_out_pkg::REG_THRESHOLD: begin
               cfg_q.threshold <= reg_wdata_i[axis_out_pkg::LEVEL_W-1:0];
            end
            default: ;
         endcase
      end
   end

   assign cfg_o = cfg_q;

   // data writes go straight to the fifo write port
   assign cpu_push_o = reg_we_i && (reg_addr_i == axis_out_pkg::REG_DATA);
   assign cpu_data_o = reg_wdata_i;

   assign data_wready_o = ~fifo_stat_i.full;
   assign interrupt_o   = (fifo_stat_i.level <= cfg_q.threshold);

   // combinational readback
   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         axis_out_pkg::REG_ENABLE: begin
            reg_rdata_o[0] = cfg_q.enable;
         end
         axis_out_pkg::REG_SOFT_RESET: begin
            reg_rdata_o[0] = cfg_q.soft_rst;
         end
         axis_out_pkg::REG_DATA: begin
            reg_rdata_o[0] = data_wready_o;
         end
         axis_out_pkg::REG_NWORDS: begin
            reg_rdata_o = cfg_q.nwords;
         end
         axis_out_pkg::REG_THRESHOLD: begin
            reg_rdata_o[axis_out_pkg::LEVEL_W-1:0] = cfg_q.threshold;
         end
         axis_out_pkg::REG_STATUS: begin
            // empty, full, level from msb down
            reg_rdata_o[$bits(axis_out_pkg::fifo_stat_t)-1:0] = fifo_stat_i;
         end
         default: begin
            reg_rdata_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== axis_out_fifo.sv ====
`default_nettype none

module axis_out_fifo (
   input  wire                               clk_i,
   input  wire                               arst_n_i,
   input  wire                               clr_i,
   input  wire                               wr_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   wr_data_i,
   input  wire                               rd_i,
   output logic [axis_out_pkg::DATA_W-1:0]   rd_data_o,
   output axis_out_pkg::fifo_stat_t          stat_o
);

   logic [axis_out_pkg::DATA_W-1:0]      mem [axis_out_pkg::FIFO_DEPTH];
   logic [axis_out_pkg::FIFO_ADDR_W-1:0] wr_ptr_q;
   logic [axis_out_pkg::FIFO_ADDR_W-1:0] rd_ptr_q;
   logic [axis_out_pkg::LEVEL_W-1:0]     level_q;
   logic                                 full;
   logic                                 empty;
   logic                                 wr_en;
   logic                                 rd_en;

   assign full  = (level_q == axis_out_pkg::FIFO_DEPTH);
   assign empty = (level_q == '0);

   // overflow and underflow attempts are dropped
   assign wr_en = wr_i & ~full;
   assign rd_en = rd_i & ~empty;

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rd_data_o <= mem[rd_ptr_q];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else if (clr_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   assign stat_o.empty = empty;
   assign stat_o.full  = full;
   assign stat_o.level = level_q;

endmodule

`default_nettype wire

// ==== axis_out_ctrl.sv ====
`default_nettype none

module axis_out_ctrl (
   input  wire                  clk_i,
   input  wire                  arst_n_i,
   input  axis_out_pkg::cfg_t   cfg_i,
   input  wire                  empty_i,
   input  wire                  axis_tready_i,
   output logic                 fifo_rd_o,
   output logic                 axis_tvalid_o,
   output logic                 beat_o
);

   axis_out_pkg::ctrl_state_e state_q;
   axis_out_pkg::ctrl_state_e state_d;
   logic                      can_pop;

   assign can_pop = cfg_i.enable & ~cfg_i.soft_rst & ~empty_i;

   assign axis_tvalid_o = (state_q == axis_out_pkg::STREAM);
   assign beat_o        = axis_tvalid_o & axis_tready_i;

   always_comb begin
      state_d   = state_q;
      fifo_rd_o = 1'b0;
      case (state_q)
         axis_out_pkg::IDLE: begin
            if (can_pop) begin
               fifo_rd_o = 1'b1;
               state_d   = axis_out_pkg::STREAM;
            end
         end
         axis_out_pkg::STREAM: begin
            // held word stays until the sink takes it
            if (axis_tready_i) begin
               if (can_pop) begin
                  fifo_rd_o = 1'b1;
               end else begin
                  state_d = axis_out_pkg::IDLE;
               end
            end
         end
         default: begin
            state_d = axis_out_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= axis_out_pkg::IDLE;
      end else if (cfg_i.soft_rst) begin
         state_q <= axis_out_pkg::IDLE;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

`default_nettype wire

// ==== axis_out_word_cnt.sv ====
`default_nettype none

module axis_out_word_cnt (
   input  wire                  clk_i,
   input  wire                  arst_n_i,
   input  axis_out_pkg::cfg_t   cfg_i,
   input  wire                  beat_i,
   input  wire                  axis_tvalid_i,
   output logic                 axis_tlast_o
);

   logic [axis_out_pkg::DATA_W-1:0] count_q;
   logic                            last_word;

   // last beat of a frame is word nwords-1 counting from zero
   assign last_word    = (count_q == cfg_i.nwords - 1'b1);
   assign axis_tlast_o = axis_tvalid_i & last_word;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
      end else if (cfg_i.soft_rst) begin
         count_q <= '0;
      end else if (beat_i) begin
         if (last_word) begin
            count_q <= '0;
         end else begin
            count_q <= count_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== axis_out_top.sv ====
`default_nettype none

module axis_out_top (
   input  wire                               clk_i,
   input  wire                               arst_n_i,
   // cpu register bus
   input  wire                               reg_we_i,
   input  axis_out_pkg::reg_addr_e           reg_addr_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   reg_wdata_i,
   output logic [axis_out_pkg::DATA_W-1:0]   reg_rdata_o,
   output logic                              data_wready_o,
   // dma input
   input  wire                               dma_tvalid_i,
   input  wire  [axis_out_pkg::DATA_W-1:0]   dma_tdata_i,
   output logic                              dma_tready_o,
   // stream output
   output logic [axis_out_pkg::DATA_W-1:0]   axis_tdata_o,
   output logic                              axis_tvalid_o,
   input  wire                               axis_tready_i,
   output logic                              axis_tlast_o,
   output logic                              interrupt_o
);

   axis_out_pkg::cfg_t              cfg;
   axis_out_pkg::fifo_stat_t        fifo_stat;
   logic                            cpu_push;
   logic [axis_out_pkg::DATA_W-1:0] cpu_data;
   logic                            fifo_wr;
   logic [axis_out_pkg::DATA_W-1:0] fifo_wdata;
   logic                            fifo_rd;
   logic [axis_out_pkg::DATA_W-1:0] rd_data;
   logic                            beat;

   axis_out_regs u_regs (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .reg_we_i     (reg_we_i),
      .reg_addr_i   (reg_addr_i),
      .reg_wdata_i  (reg_wdata_i),
      .reg_rdata_o  (reg_rdata_o),
      .fifo_stat_i  (fifo_stat),
      .cfg_o        (cfg),
      .cpu_push_o   (cpu_push),
      .cpu_data_o   (cpu_data),
      .data_wready_o(data_wready_o),
      .interrupt_o  (interrupt_o)
   );

   assign dma_tready_o = ~fifo_stat.full;

   // dma wins, a cpu word in the same cycle is lost
   assign fifo_wr    = (dma_tvalid_i | cpu_push) & ~fifo_stat.full;
   assign fifo_wdata = dma_tvalid_i ? dma_tdata_i : cpu_data;

   axis_out_fifo u_fifo (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .clr_i    (cfg.soft_rst),
      .wr_i     (fifo_wr),
      .wr_data_i(fifo_wdata),
      .rd_i     (fifo_rd),
      .rd_data_o(rd_data),
      .stat_o   (fifo_stat)
   );

   axis_out_ctrl u_ctrl (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cfg_i        (cfg),
      .empty_i      (fifo_stat.empty),
      .axis_tready_i(axis_tready_i),
      .fifo_rd_o    (fifo_rd),
      .axis_tvalid_o(axis_tvalid_o),
      .beat_o       (beat)
   );

   axis_out_word_cnt u_word_cnt (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .cfg_i        (cfg),
      .beat_i       (beat),
      .axis_tvalid_i(axis_tvalid_o),
      .axis_tlast_o (axis_tlast_o)
   );

   assign axis_tdata_o = rd_data;

endmodule

`default_nettype wire

// ==== axis_out_sva.sv ====
`default_nettype none

module axis_out_sva (
   input wire                              clk_i,
   input wire                              arst_n_i,
   input wire                              soft_rst_i,
   input wire                              fifo_empty_i,
   input wire                              fifo_full_i,
   input wire                              dma_tready_i,
   input wire                              axis_tvalid_i,
   input wire                              axis_tready_i,
   input wire [axis_out_pkg::DATA_W-1:0]   axis_tdata_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned fail_cnt = 0;

   // a stalled beat keeps its word
   a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i || soft_rst_i)
      axis_tvalid_i && !axis_tready_i |=> axis_tvalid_i && $stable(axis_tdata_i))
   else begin
      fail_cnt++;
      $error("tvalid or tdata changed while tready was low");
   end

   // nothing to present without a write first
   a_no_early_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      fifo_empty_i && !axis_tvalid_i |=> !axis_tvalid_i)
   else begin
      fail_cnt++;
      $error("tvalid rose while the FIFO was empty");
   end

   a_dma_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      dma_tready_i == !fifo_full_i)
   else begin
      fail_cnt++;
      $error("dma_tready does not follow FIFO full");
   end

endmodule

bind axis_out_top axis_out_sva u_sva (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .soft_rst_i   (cfg.soft_rst),
   .fifo_empty_i (fifo_stat.empty),
   .fifo_full_i  (fifo_stat.full),
   .dma_tready_i (dma_tready_o),
   .axis_tvalid_i(axis_tvalid_o),
   .axis_tready_i(axis_tready_i),
   .axis_tdata_i (axis_tdata_o)
);

`default_nettype wire

// ==== tb_axis_out.sv ====
`default_nettype none

module tb_axis_out;
   timeunit 1ns;
   timeprecision 1ps;

   logic                            clk_i = 1'b0;
   logic                            arst_n_i;
   logic                            reg_we_i;
   axis_out_pkg::reg_addr_e         reg_addr_i;
   logic [axis_out_pkg::DATA_W-1:0] reg_wdata_i;
   logic [axis_out_pkg::DATA_W-1:0] reg_rdata_o;
   logic                            data_wready_o;
   logic                            dma_tvalid_i;
   logic [axis_out_pkg::DATA_W-1:0] dma_tdata_i;
   logic                            dma_tready_o;
   logic [axis_out_pkg::DATA_W-1:0] axis_tdata_o;
   logic                            axis_tvalid_o;
   logic                            axis_tready_i;
   logic                            axis_tlast_o;
   logic                            interrupt_o;

   // words written but not yet accepted on the stream
   logic [axis_out_pkg::DATA_W-1:0] ref_q[$];
   logic [axis_out_pkg::DATA_W-1:0] nwords = '0;
   logic [axis_out_pkg::DATA_W-1:0] frame_cnt = '0;
   int                              threshold = 0;
   bit                              stall_en = 1'b0;
   bit                              sink_block = 1'b0;
   bit                              irq_chk = 1'b0;
   string                           test_name = "reset";
   int                              err_cnt = 0;
   int                              err_mark = 0;
   int                              tests_passed = 0;
   int                              tests_failed = 0;

   axis_out_top dut (.*);

   always #5 clk_i = ~clk_i;

   function automatic int error_total();
      return err_cnt + dut.u_sva.fail_cnt;
   endfunction

   task automatic check(string what, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("mismatch %s %s: expected %0h actual %0h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic report_test();
      if (error_total() == err_mark) begin
         tests_passed++;
         $display("%s: passed", test_name);
      end else begin
         tests_failed++;
         $display("%s: failed", test_name);
      end
      err_mark = error_total();
   endtask

   // every stimulus edge also picks the sink's tready
   task automatic tick();
      @(posedge clk_i);
      axis_tready_i <= sink_block ? 1'b0 : (stall_en ? ($urandom % 4 != 0) : 1'b1);
   endtask

   task automatic cpu_write(axis_out_pkg::reg_addr_e addr, logic [31:0] data);
      tick();
      reg_we_i    <= 1'b1;
      reg_addr_i  <= addr;
      reg_wdata_i <= data;
      tick();
      reg_we_i    <= 1'b0;
   endtask

   task automatic push_word(logic [31:0] data, bit keep);
      cpu_write(axis_out_pkg::REG_DATA, data);
      if (keep) begin
         ref_q.push_back(data);
      end
   endtask

   task automatic dma_send(logic [31:0] data);
      int i;
      tick();
      dma_tvalid_i <= 1'b1;
      dma_tdata_i  <= data;
      for (i = 0; i < 100; i++) begin
         @(negedge clk_i);
         if (dma_tready_o) break;
         tick();
      end
      if (i == 100) begin
         $display("%s: timeout waiting for dma_tready", test_name);
         err_cnt++;
      end
      tick();
      dma_tvalid_i <= 1'b0;
      ref_q.push_back(data);
   endtask

   task automatic read_status(output axis_out_pkg::fifo_stat_t stat);
      tick();
      reg_addr_i <= axis_out_pkg::REG_STATUS;
      @(negedge clk_i);
      stat = reg_rdata_o[$bits(axis_out_pkg::fifo_stat_t)-1:0];
   endtask

   task automatic wait_drain();
      int i;
      for (i = 0; i < 2000; i++) begin
         @(negedge clk_i);
         if (ref_q.size() == 0 && !axis_tvalid_o) break;
         tick();
      end
      if (i == 2000) begin
         $display("%s: timeout waiting for the stream to drain", test_name);
         err_cnt++;
      end
   endtask

   // stream monitor, sampled mid-cycle
   always @(negedge clk_i) begin
      if (arst_n_i) begin
         if (irq_chk) begin
            check("interrupt", (ref_q.size() - axis_tvalid_o) <= threshold, interrupt_o);
         end
         check("tlast", axis_tvalid_o && (frame_cnt == nwords - 1), axis_tlast_o);
         if (axis_tvalid_o && axis_tready_i) begin
            if (ref_q.size() == 0) begin
               $display("%s: word %0h accepted but none expected", test_name, axis_tdata_o);
               err_cnt++;
            end else begin
               check("tdata", ref_q.pop_front(), axis_tdata_o);
            end
            frame_cnt = (frame_cnt == nwords - 1) ? '0 : frame_cnt + 1;
         end
      end
   end

   initial begin
      axis_out_pkg::fifo_stat_t stat;
      axis_out_pkg::fifo_stat_t stat_exp;
      int i;
      void'($urandom(3086));
      arst_n_i      = 1'b0;
      reg_we_i      = 1'b0;
      reg_addr_i    = axis_out_pkg::REG_ENABLE;
      reg_wdata_i   = '0;
      dma_tvalid_i  = 1'b0;
      dma_tdata_i   = '0;
      axis_tready_i = 1'b1;
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;

      test_name = "cpu_writes";
      cpu_write(axis_out_pkg::REG_NWORDS, 4);
      nwords = 4;
      cpu_write(axis_out_pkg::REG_ENABLE, 1);
      for (i = 0; i < 8; i++) begin
         push_word($urandom, 1'b1);
      end
      wait_drain();
      report_test();

      test_name = "dma_burst";
      stall_en = 1'b1;
      for (i = 0; i < 16; i++) begin
         dma_send($urandom);
      end
      wait_drain();
      stall_en = 1'b0;
      report_test();

      // frames of four, tlast on words 4, 8 and 12
      test_name = "tlast_frames";
      for (i = 0; i < 12; i++) begin
         push_word($urandom, 1'b1);
      end
      wait_drain();
      report_test();

      test_name = "fifo_full";
      cpu_write(axis_out_pkg::REG_ENABLE, 0);
      for (i = 0; i < 17; i++) begin
         push_word($urandom, i < 16);
      end
      read_status(stat);
      stat_exp = '{empty: 1'b0, full: 1'b1, level: 5'd16};
      check("status", stat_exp, stat);
      check("data_wready", 1'b0, data_wready_o);
      check("dma_tready", 1'b0, dma_tready_o);
      cpu_write(axis_out_pkg::REG_ENABLE, 1);
      wait_drain();
      report_test();

      test_name = "interrupt";
      cpu_write(axis_out_pkg::REG_THRESHOLD, 3);
      threshold = 3;
      cpu_write(axis_out_pkg::REG_ENABLE, 0);
      irq_chk = 1'b1;
      for (i = 0; i < 6; i++) begin
         push_word($urandom, 1'b1);
      end
      stall_en = 1'b1;
      cpu_write(axis_out_pkg::REG_ENABLE, 1);
      wait_drain();
      stall_en = 1'b0;
      irq_chk  = 1'b0;
      report_test();

      // sink held off so one word sits on the stream
      test_name = "soft_reset";
      sink_block = 1'b1;
      for (i = 0; i < 5; i++) begin
         push_word($urandom, 1'b1);
      end
      cpu_write(axis_out_pkg::REG_SOFT_RESET, 1);
      for (i = 0; i < 20; i++) begin
         read_status(stat);
         if (stat.empty) break;
      end
      check("fifo empty", 1'b1, stat.empty);
      check("tvalid", 1'b0, axis_tvalid_o);
      ref_q.delete();
      frame_cnt = '0;
      sink_block = 1'b0;
      cpu_write(axis_out_pkg::REG_SOFT_RESET, 0);
      cpu_write(axis_out_pkg::REG_NWORDS, 3);
      nwords = 3;
      cpu_write(axis_out_pkg::REG_ENABLE, 1);
      for (i = 0; i < 3; i++) begin
         push_word($urandom, 1'b1);
      end
      wait_drain();
      report_test();

      $display("tests passed %0d, failed %0d, errors %0d",
               tests_passed, tests_failed, error_total());
      if (tests_failed == 0 && error_total() == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
axis_out_pkg.sv
axis_out_regs.sv
axis_out_fifo.sv
axis_out_ctrl.sv
axis_out_word_cnt.sv
axis_out_top.sv
axis_out_sva.sv
tb_axis_out.sv
